// File: verif/gs_ports_vectors.txt
// columns: kind addr data sig expected, hex; kind 1 io write, 2 io read, 3 mem read
// sig 0 none, 1 dout, 2 host dout, 3 mode, 4 pg0, 5 pg1, 6 data port, 7 data bit,
// 8 command bit, 9 sound as {datnvol, addr}
2 000f 00 1 30
2 000f 00 3 30
1 000f a5 3 a5
2 000f 00 1 a5
1 0000 85 4 0a
2 000f 00 5 0b
1 000a 00 7 01
1 000f 38 3 38
1 0000 c3 4 87
2 000f 00 5 0b
1 0010 22 5 44
2 000f 00 4 87
2 000a 00 7 00
1 0003 5c 6 5c
2 0002 00 7 00
2 0002 00 2 00
2 0001 00 2 00
2 0004 00 2 00
1 0005 00 8 00
1 0009 20 9 03
1 000b 00 8 01
1 0009 df 9 03
2 000b 00 8 00
1 0006 11 9 00
1 0007 22 9 01
1 0008 33 9 02
1 0016 44 9 04
1 0017 55 9 05
1 0018 66 9 06
1 0019 77 9 07
3 6500 3c 9 09
3 7f00 5a 9 0b
1 000f 34 3 34
3 6500 3c 9 0d
3 7e00 41 9 0e
3 5f00 12 0 00
3 8000 13 0 00
2 0041 00 0 00
1 0046 99 0 00

// File: src.f
+incdir+hw
hw/gs_ports_pkg.sv
hw/gs_stage_if.sv
hw/bus_cycle_sync.sv
hw/port_decode.sv
hw/gs_control_regs.sv
hw/sound_writer.sv
hw/read_mux.sv
hw/gs_ports_top.sv
verif/tb_clock_gen.sv
verif/tb_gs_ports.sv

// File: run_sim.sh
#!/bin/sh
# build the gs port block testbench with verilator and run it
# passes only if the testbench printed its pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -f src.f \
	--top-module tb_gs_ports -Mdir obj_dir -o sim_gs_ports
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_gs_ports)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1

// File: verif/tb_gs_ports.sv
// gs port block testbench
// replays bus cycles from the vector file, checks regs, flag strobes, sound writes, read bus

`timescale 1ns/10ps
`include "gs_ports_params.svh"

module tb_gs_ports;

	localparam int RESET_CLKS = 16;
	localparam int MAX_VEC    = 64;
	localparam int ACT_CLKS   = 3;  // strobes held low
	localparam int CYC_CLKS   = 7;  // then 4 idle
	localparam int WD_CLKS    = 50; // watchdog budget per vector

	localparam logic [3:0] K_IOWR  = 4'd1;
	localparam logic [3:0] K_IORD  = 4'd2;
	localparam logic [3:0] K_MEMRD = 4'd3;

	localparam logic [3:0] S_DOUT  = 4'd1;
	localparam logic [3:0] S_HOST  = 4'd2; // dout from the lfsr host inputs
	localparam logic [3:0] S_MODE  = 4'd3;
	localparam logic [3:0] S_PG0   = 4'd4;
	localparam logic [3:0] S_PG1   = 4'd5;
	localparam logic [3:0] S_DPORT = 4'd6;
	localparam logic [3:0] S_SND   = 4'd9; // 7 and 8 are the flag bits

	string sig_names [10] = '{"none", "dout", "host_dout", "mode", "pg0", "pg1",
		"data_port", "data_bit", "command_bit", "sound"};

	logic        cpu_clock;
	logic        rst_n;
	logic [15:0] a;
	logic [7:0]  din;
	logic [7:0]  dout;
	logic        busin;
	logic        iorq_n;
	logic        mreq_n;
	logic        rd_n;
	logic        wr_n;
	logic [7:0]  command_port_input;
	logic [7:0]  data_port_input;
	logic        data_bit_input;
	logic        command_bit_input;
	logic [7:0]  data_port_output;
	logic        data_bit_output;
	logic        data_bit_wr;
	logic        command_bit_output;
	logic        command_bit_wr;
	logic        mode_inv7b;
	logic        mode_pan4ch;
	logic        clksel1;
	logic        clksel0;
	logic        mode_expag;
	logic        mode_8chans;
	logic        mode_ramro;
	logic        mode_norom;
	logic [7:0]  mode_pg0;
	logic [7:0]  mode_pg1;
	logic        snd_wrtoggle;
	logic        snd_datnvol;
	logic [2:0]  snd_addr;
	logic [7:0]  snd_data;
	logic [7:0]  mode_bits;  // config as seen on the pins

	logic [15:0] vec_mem [0:MAX_VEC*5-1]; // five words per vector
	int          num_vec = 0;
	int          errors  = 0;
	int          checks  = 0;
	logic [15:0] lfsr_state;

	assign mode_bits = {mode_inv7b, mode_pan4ch, clksel1, clksel0,
		mode_expag, mode_8chans, mode_ramro, mode_norom};

	tb_clock_gen #(.RESET_CLKS(RESET_CLKS)) u_clk (.cpu_clock(cpu_clock), .rst_n(rst_n));

	gs_ports_top uut (.*);

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state); // one step per bit
			v = {v[6:0], lfsr_state[0]};
		end
	endtask

	function automatic logic is_vol_port(input logic [5:0] p);
		is_vol_port = (p == `GS_PORT_VOL1) || (p == `GS_PORT_VOL2) || (p == `GS_PORT_VOL3) ||
			(p == `GS_PORT_VOL4) || (p == `GS_PORT_VOL5) || (p == `GS_PORT_VOL6) ||
			(p == `GS_PORT_VOL7) || (p == `GS_PORT_VOL8);
	endfunction

	task automatic check(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		checks++;
		if (expected !== actual)
		begin
			$display("FAILED %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic run_vector(input int idx);
		logic [3:0]  kind;
		logic [15:0] addr;
		logic [5:0]  port;
		logic [7:0]  data;
		logic [3:0]  sig;
		logic [7:0]  exp_val;
		logic [7:0]  host_cmd;
		logic [7:0]  host_dat;
		logic [7:0]  host_bits; // [1] data bit, [0] command bit
		logic [7:0]  dout_exp;
		logic        port_ok;
		logic        want_dbit;
		logic        want_cbit;
		logic        want_snd;
		logic        dbit_val;
		logic        cbit_val;
		logic        busin_exp;
		logic        got_dbit;
		logic        got_cbit;
		logic        last_tog;
		int          n_dbit;
		int          n_cbit;
		int          n_snd;
		string       tname;

		kind    = vec_mem[idx*5][3:0];
		addr    = vec_mem[idx*5+1];
		data    = vec_mem[idx*5+2][7:0];
		sig     = vec_mem[idx*5+3][3:0];
		exp_val = vec_mem[idx*5+4][7:0];
		port    = addr[5:0];
		port_ok = (addr[7:6] == 2'b00) && (kind != K_MEMRD); // our io ports only
		tname   = $sformatf("vec%0d_%s", idx, sig_names[sig]);

		// what the port rules say should happen
		want_dbit = port_ok && ((kind == K_IOWR && port == `GS_PORT_ZXDATWR) ||
			(kind == K_IORD && port == `GS_PORT_ZXDATRD) || port == `GS_PORT_MIRROR1);
		want_cbit = port_ok && (port == `GS_PORT_CLRCBIT || port == `GS_PORT_MIRROR2);
		want_snd  = (kind == K_MEMRD && addr[15:13] == 3'b011) ||
			(kind == K_IOWR && port_ok && is_vol_port(port));
		dbit_val  = (port == `GS_PORT_MIRROR1) ? exp_val[0] : (kind == K_IOWR);
		cbit_val  = (port == `GS_PORT_MIRROR2) ? exp_val[0] : 1'b0;
		busin_exp = !(kind == K_IORD && port_ok);

		draw_bits(8, host_cmd);
		draw_bits(8, host_dat);
		draw_bits(2, host_bits);
		case (port)
			`GS_PORT_ZXCMD:   dout_exp = host_cmd;
			`GS_PORT_ZXDATRD: dout_exp = host_dat;
			`GS_PORT_ZXSTAT:  dout_exp = {host_bits[1], 6'd0, host_bits[0]};
			default:          dout_exp = 8'h00;
		endcase
		if (sig != S_HOST)
			dout_exp = exp_val;

		n_dbit   = 0;
		n_cbit   = 0;
		n_snd    = 0;
		got_dbit = 1'b0;
		got_cbit = 1'b0;
		last_tog = snd_wrtoggle;
		for (int c = 0; c < CYC_CLKS; c++)
		begin
			@(posedge cpu_clock);
			if (c == 0)
			begin
				a                  <= addr;
				din                <= data;
				command_port_input <= host_cmd;
				data_port_input    <= host_dat;
				data_bit_input     <= host_bits[1];
				command_bit_input  <= host_bits[0];
				iorq_n             <= (kind == K_MEMRD);
				mreq_n             <= (kind != K_MEMRD);
				rd_n               <= (kind == K_IOWR);
				wr_n               <= (kind != K_IOWR);
			end
			else if (c == ACT_CLKS)
			begin
				iorq_n <= 1'b1; // back to idle
				mreq_n <= 1'b1;
				rd_n   <= 1'b1;
				wr_n   <= 1'b1;
			end
			@(negedge cpu_clock); // outputs settled here
			check($sformatf("vec%0d_busin", idx), 16'((c < ACT_CLKS) ? busin_exp : 1'b1),
				16'(busin));
			if (c == 1 && (sig == S_DOUT || sig == S_HOST))
				check(tname, 16'(dout_exp), 16'(dout));
			if (data_bit_wr)
			begin
				n_dbit++;
				got_dbit = data_bit_output;
			end
			if (command_bit_wr)
			begin
				n_cbit++;
				got_cbit = command_bit_output;
			end
			if (snd_wrtoggle !== last_tog)
			begin
				n_snd++;
				last_tog = snd_wrtoggle;
			end
		end

		checks += 3;
		if (n_dbit != (want_dbit ? 1 : 0))
		begin
			$display("vector %0d: data_bit_wr pulsed %0d times instead of %0d", idx, n_dbit,
				want_dbit ? 1 : 0);
			errors++;
		end
		else if (want_dbit)
			check($sformatf("vec%0d_data_bit", idx), 16'(dbit_val), 16'(got_dbit));
		if (n_cbit != (want_cbit ? 1 : 0))
		begin
			$display("vector %0d: command_bit_wr pulsed %0d times instead of %0d", idx,
				n_cbit, want_cbit ? 1 : 0);
			errors++;
		end
		else if (want_cbit)
			check($sformatf("vec%0d_command_bit", idx), 16'(cbit_val), 16'(got_cbit));
		if (n_snd != (want_snd ? 1 : 0))
		begin
			$display("vector %0d: snd_wrtoggle flipped %0d times instead of %0d", idx,
				n_snd, want_snd ? 1 : 0);
			errors++;
		end

		case (sig)
			S_MODE:  check(tname, 16'(exp_val), 16'(mode_bits));
			S_PG0:   check(tname, 16'(exp_val), 16'(mode_pg0));
			S_PG1:   check(tname, 16'(exp_val), 16'(mode_pg1));
			S_DPORT: check(tname, 16'(exp_val), 16'(data_port_output));
			S_SND:
			begin
				check(tname, 16'(exp_val), 16'({4'd0, snd_datnvol, snd_addr}));
				check($sformatf("vec%0d_snd_data", idx), 16'(data), 16'(snd_data));
			end
			default:
				;
		endcase
	endtask

	initial
	begin
		a                  = '0;
		din                = '0;
		iorq_n             = 1'b1;
		mreq_n             = 1'b1;
		rd_n               = 1'b1;
		wr_n               = 1'b1;
		command_port_input = '0;
		data_port_input    = '0;
		data_bit_input     = 1'b0;
		command_bit_input  = 1'b0;
		lfsr_state         = 16'd30;
		for (int i = 0; i < MAX_VEC*5; i++)
			vec_mem[i] = '0;
		$readmemh("verif/gs_ports_vectors.txt", vec_mem);
		while (num_vec < MAX_VEC && vec_mem[num_vec*5] != '0) // kind 0 ends the list
			num_vec++;
		if (num_vec == 0)
		begin
			$display("no vectors were read from verif/gs_ports_vectors.txt");
			errors++;
		end
		@(posedge rst_n);
		for (int i = 0; i < num_vec; i++)
			run_vector(i);
		$display("vectors %0d, checks %0d, errors %0d", num_vec, checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// watchdog, sized from the vector count
	initial
	begin
		wait (num_vec > 0);
		repeat (RESET_CLKS + num_vec * WD_CLKS) @(posedge cpu_clock);
		$display("timeout: the vectors did not finish within %0d clocks",
			RESET_CLKS + num_vec * WD_CLKS);
		$display("vectors %0d, checks %0d, errors %0d", num_vec, checks, errors + 1);
		$display("TEST FAIL");
		$finish;
	end

endmodule

// File: verif/tb_clock_gen.sv
// testbench clock and reset
// free-running cpu clock, reset held low for the first cycles

`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int HALF_PERIOD = 5,  // 10 ns clock
	parameter int RESET_CLKS  = 16
) (
	output logic cpu_clock,
	output logic rst_n
);

	initial
	begin
		cpu_clock = 1'b0;
		forever #(HALF_PERIOD) cpu_clock = ~cpu_clock;
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CLKS) @(posedge cpu_clock);
		rst_n <= 1'b1; // lets go on a rising edge
	end

endmodule

// File: hw/gs_ports_top.sv
// gs i/o port block top
// bus sync, decode, control regs, sound writes and read mux

`timescale 1ns/10ps

module gs_ports_top
	import gs_ports_pkg::*;
(
	input  logic        cpu_clock,
	input  logic        rst_n,
	input  logic [15:0] a,
	input  gs_data_t    din,
	output gs_data_t    dout,
	output logic        busin, // 0 while we drive the bus
	input  logic        iorq_n,
	input  logic        mreq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  gs_data_t    command_port_input,
	input  gs_data_t    data_port_input,
	input  logic        data_bit_input,
	input  logic        command_bit_input,
	output gs_data_t    data_port_output,
	output logic        data_bit_output,
	output logic        data_bit_wr,
	output logic        command_bit_output,
	output logic        command_bit_wr,
	output logic        mode_inv7b,
	output logic        mode_pan4ch,
	output logic        clksel1,
	output logic        clksel0,
	output logic        mode_expag,
	output logic        mode_8chans,
	output logic        mode_ramro,
	output logic        mode_norom,
	output gs_data_t    mode_pg0,
	output gs_data_t    mode_pg1,
	output logic        snd_wrtoggle,
	output logic        snd_datnvol,
	output gs_chan_t    snd_addr,
	output gs_data_t    snd_data
);
	gs_cfg_t cfg;

	bus_cycle_if cyc_if ();
	decoded_if   dec_if ();

	// config fanned out as separate mode pins
	assign {mode_inv7b, mode_pan4ch, clksel1, clksel0} = cfg[7:4];
	assign {mode_expag, mode_8chans, mode_ramro, mode_norom} = cfg[3:0];

	bus_cycle_sync u_sync (
		.cpu_clock(cpu_clock), .rst_n(rst_n), .a(a), .din(din),
		.iorq_n(iorq_n), .mreq_n(mreq_n), .rd_n(rd_n), .wr_n(wr_n),
		.cyc(cyc_if.src)
	);

	port_decode u_decode (.cpu_clock(cpu_clock), .rst_n(rst_n), .cyc(cyc_if.dst), .dec(dec_if.src));

	gs_control_regs u_regs (
		.cpu_clock(cpu_clock), .rst_n(rst_n), .dec(dec_if.dst), .cfg(cfg),
		.mode_pg0(mode_pg0), .mode_pg1(mode_pg1), .data_port_output(data_port_output),
		.data_bit_output(data_bit_output), .data_bit_wr(data_bit_wr),
		.command_bit_output(command_bit_output), .command_bit_wr(command_bit_wr)
	);

	sound_writer u_snd (
		.cpu_clock(cpu_clock), .rst_n(rst_n), .dec(dec_if.dst), .cfg(cfg),
		.snd_wrtoggle(snd_wrtoggle), .snd_datnvol(snd_datnvol),
		.snd_addr(snd_addr), .snd_data(snd_data)
	);

	read_mux u_rdmux (
		.a(a[7:0]), .iorq_n(iorq_n), .rd_n(rd_n), .cfg(cfg),
		.command_port_input(command_port_input), .data_port_input(data_port_input),
		.data_bit_input(data_bit_input), .command_bit_input(command_bit_input),
		.dout(dout), .busin(busin)
	);

endmodule

// File: hw/read_mux.sv
// z80 read data mux
// combinational from the live pins, plus bus direction

`timescale 1ns/10ps
`include "gs_ports_params.svh"

module read_mux
	import gs_ports_pkg::*;
(
	input  logic [7:0] a,
	input  logic       iorq_n,
	input  logic       rd_n,
	input  gs_cfg_t    cfg,
	input  gs_data_t   command_port_input,
	input  gs_data_t   data_port_input,
	input  logic       data_bit_input,
	input  logic       command_bit_input,
	output gs_data_t   dout,
	output logic       busin // 1 input, 0 we drive
);

	// only io reads of our own ports turn the bus around
	assign busin = ~((a[7:6] == `GS_PORT_HI_BITS) & ~iorq_n & ~rd_n);

	always_comb
	begin
		case (a[5:0])
			`GS_PORT_ZXCMD:   dout = command_port_input;
			`GS_PORT_ZXDATRD: dout = data_port_input;
			`GS_PORT_ZXSTAT:  dout = {data_bit_input, 6'd0, command_bit_input};
			`GS_PORT_GSCFG0:  dout = cfg;
			default:          dout = '0;
		endcase
	end

endmodule

// File: hw/sound_writer.sv
// sound write path, third stage
// samples and volumes to the sound system, flagged by a toggle

`timescale 1ns/10ps

module sound_writer
	import gs_ports_pkg::*;
(
	input  logic     cpu_clock,
	input  logic     rst_n,
	decoded_if.dst   dec,
	input  gs_cfg_t  cfg,
	output logic     snd_wrtoggle, // flips once per write
	output logic     snd_datnvol,  // 1 sample, 0 volume
	output gs_chan_t snd_addr,
	output gs_data_t snd_data
);

	always_ff @(posedge cpu_clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			snd_wrtoggle <= 1'b0;
			snd_datnvol  <= 1'b0;
			snd_addr     <= '0;
			snd_data     <= '0;
		end
		else if (dec.op == OP_SAMPLE)
		begin
			snd_wrtoggle <= ~snd_wrtoggle;
			snd_datnvol  <= 1'b1;
			// 4ch mode drops a[10]
			snd_addr     <= cfg.chans8 ? dec.chan_sel : {1'b0, dec.chan_sel[1:0]};
			snd_data     <= dec.data;
		end
		else if (dec.op == OP_VOL)
		begin
			snd_wrtoggle <= ~snd_wrtoggle;
			snd_datnvol  <= 1'b0;
			snd_addr     <= dec.volnum;
			snd_data     <= dec.data;
		end
	end

endmodule

// File: hw/gs_control_regs.sv
// gs control registers, third stage
// config, memory pages, data port, port $09 trace and host flag strobes

`timescale 1ns/10ps
`include "gs_ports_params.svh"

module gs_control_regs
	import gs_ports_pkg::*;
(
	input  logic     cpu_clock,
	input  logic     rst_n,
	decoded_if.dst   dec,
	output gs_cfg_t  cfg,
	output gs_data_t mode_pg0,
	output gs_data_t mode_pg1,
	output gs_data_t data_port_output,
	output logic     data_bit_output,
	output logic     data_bit_wr,     // one clock strobe
	output logic     command_bit_output,
	output logic     command_bit_wr   // one clock strobe
);
	logic port09_bit5; // feeds mirror2

	always_ff @(posedge cpu_clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cfg              <= gs_cfg_t'(`GS_CFG_RESET);
			mode_pg0         <= '0;
			mode_pg1         <= '0;
			data_port_output <= '0;
			port09_bit5      <= 1'b0;
		end
		else
		begin
			case (dec.op)
				OP_CFG:
					cfg <= gs_cfg_t'(dec.data);
				OP_PAGE0:
				begin
					if (!cfg.expag) // normal paging, pg1 is pg0 + 1
					begin
						mode_pg0 <= {dec.data[6:0], 1'b0};
						mode_pg1 <= {dec.data[6:0], 1'b1};
					end
					else
						mode_pg0 <= {dec.data[6:0], dec.data[7]}; // bit 7 as lsb
				end
				OP_PAGEX:
					if (cfg.expag) // ignored in normal paging
						mode_pg1 <= {dec.data[6:0], dec.data[7]};
				OP_DATWR:
					data_port_output <= dec.data;
				OP_VOL:
					if (dec.volnum == 3'd3) // port $09
						port09_bit5 <= dec.data[5];
				default:
					;
			endcase
		end
	end

	// flag bits toward host
	always_ff @(posedge cpu_clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			data_bit_output    <= 1'b0;
			data_bit_wr        <= 1'b0;
			command_bit_output <= 1'b0;
			command_bit_wr     <= 1'b0;
		end
		else
		begin
			data_bit_wr    <= 1'b0;
			command_bit_wr <= 1'b0;
			case (dec.op)
				OP_DATRD:
				begin
					data_bit_output <= 1'b0; // host may send again
					data_bit_wr     <= 1'b1;
				end
				OP_DATWR:
				begin
					data_bit_output <= 1'b1;
					data_bit_wr     <= 1'b1;
				end
				OP_MIRROR1:
				begin
					data_bit_output <= ~mode_pg0[0];
					data_bit_wr     <= 1'b1;
				end
				OP_CLRCBIT:
				begin
					command_bit_output <= 1'b0;
					command_bit_wr     <= 1'b1;
				end
				OP_MIRROR2:
				begin
					command_bit_output <= port09_bit5;
					command_bit_wr     <= 1'b1;
				end
				default:
					;
			endcase
		end
	end

endmodule

// File: hw/port_decode.sv
// port decode, second stage
// bus cycle pulse to a registered op, volume index and payload

`timescale 1ns/10ps
`include "gs_ports_params.svh"

module port_decode
	import gs_ports_pkg::*;
(
	input  logic     cpu_clock,
	input  logic     rst_n,
	bus_cycle_if.dst cyc,
	decoded_if.src   dec
);
	gs_port_t port;
	port_op_e op_nxt;
	gs_chan_t vol_nxt;
	logic     is_vol;

	assign port = cyc.addr[5:0];

	// volume ports, two groups of four
	always_comb
	begin
		vol_nxt = 3'd0;
		is_vol  = 1'b1;
		case (port)
			`GS_PORT_VOL1: vol_nxt = 3'd0;
			`GS_PORT_VOL2: vol_nxt = 3'd1;
			`GS_PORT_VOL3: vol_nxt = 3'd2;
			`GS_PORT_VOL4: vol_nxt = 3'd3;
			`GS_PORT_VOL5: vol_nxt = 3'd4;
			`GS_PORT_VOL6: vol_nxt = 3'd5;
			`GS_PORT_VOL7: vol_nxt = 3'd6;
			`GS_PORT_VOL8: vol_nxt = 3'd7;
			default:       is_vol  = 1'b0;
		endcase
	end

	always_comb
	begin
		op_nxt = OP_NONE;
		if (cyc.mem_rd)
			op_nxt = OP_SAMPLE;
		else if (cyc.io_wr)
		begin
			case (port)
				`GS_PORT_MPAG:    op_nxt = OP_PAGE0;
				`GS_PORT_MPAGEX:  op_nxt = OP_PAGEX;
				`GS_PORT_ZXDATWR: op_nxt = OP_DATWR;
				`GS_PORT_CLRCBIT: op_nxt = OP_CLRCBIT;
				`GS_PORT_MIRROR1: op_nxt = OP_MIRROR1;
				`GS_PORT_MIRROR2: op_nxt = OP_MIRROR2;
				`GS_PORT_GSCFG0:  op_nxt = OP_CFG;
				default:          op_nxt = is_vol ? OP_VOL : OP_NONE;
			endcase
		end
		else if (cyc.io_rd)
		begin
			case (port) // clear and mirrors fire on reads too
				`GS_PORT_ZXDATRD: op_nxt = OP_DATRD;
				`GS_PORT_CLRCBIT: op_nxt = OP_CLRCBIT;
				`GS_PORT_MIRROR1: op_nxt = OP_MIRROR1;
				`GS_PORT_MIRROR2: op_nxt = OP_MIRROR2;
				default:          op_nxt = OP_NONE;
			endcase
		end
	end

	always_ff @(posedge cpu_clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			dec.op       <= OP_NONE;
			dec.volnum   <= '0;
			dec.chan_sel <= '0;
			dec.data     <= '0;
		end
		else
		begin
			dec.op       <= op_nxt; // one clock per pulse
			dec.volnum   <= vol_nxt;
			dec.chan_sel <= cyc.addr[10:8];
			dec.data     <= cyc.data;
		end
	end

endmodule

// File: hw/bus_cycle_sync.sv
// z80 bus cycle sync, first stage
// one pulse per io or sample read cycle, with address and data caught alongside

`timescale 1ns/10ps
`include "gs_ports_params.svh"

module bus_cycle_sync
	import gs_ports_pkg::*;
(
	input  logic        cpu_clock,
	input  logic        rst_n,
	input  logic [15:0] a,
	input  gs_data_t    din,
	input  logic        iorq_n,
	input  logic        mreq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	bus_cycle_if.src    cyc
);
	logic port_en;
	logic mem_en;
	logic iowr_go;
	logic iord_go;
	logic memrd_go;
	logic iowrn_reg; // strobes from last edge, high = idle
	logic iordn_reg;
	logic merdn_reg;

	assign port_en = (a[7:6] == `GS_PORT_HI_BITS);
	assign mem_en  = (a[15:13] == `GS_MEM_HI_BITS);

	// active now, idle on the edge before
	assign iowr_go  = port_en & ~iorq_n & ~wr_n & iowrn_reg;
	assign iord_go  = port_en & ~iorq_n & ~rd_n & iordn_reg;
	assign memrd_go = mem_en & ~mreq_n & ~rd_n & merdn_reg;

	always_ff @(posedge cpu_clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			iowrn_reg  <= 1'b1;
			iordn_reg  <= 1'b1;
			merdn_reg  <= 1'b1;
			cyc.io_wr  <= 1'b0;
			cyc.io_rd  <= 1'b0;
			cyc.mem_rd <= 1'b0;
			cyc.addr   <= '0;
			cyc.data   <= '0;
		end
		else
		begin
			iowrn_reg  <= iorq_n | wr_n;
			iordn_reg  <= iorq_n | rd_n;
			merdn_reg  <= mreq_n | rd_n;
			cyc.io_wr  <= iowr_go;
			cyc.io_rd  <= iord_go;
			cyc.mem_rd <= memrd_go;
			if (iowr_go | iord_go | memrd_go) // hold until next cycle
			begin
				cyc.addr <= a[10:0];
				cyc.data <= din;
			end
		end
	end

endmodule

// File: hw/gs_stage_if.sv
// pipeline stage links
// bus cycle pulses into decode, decoded ops into the register stages

`timescale 1ns/10ps

interface bus_cycle_if
	import gs_ports_pkg::*;
();
	logic         io_wr;  // one clock per cycle
	logic         io_rd;
	logic         mem_rd; // sample window read
	gs_cap_addr_t addr;
	gs_data_t     data;

	modport src (output io_wr, output io_rd, output mem_rd, output addr, output data);
	modport dst (input io_wr, input io_rd, input mem_rd, input addr, input data);
endinterface

interface decoded_if
	import gs_ports_pkg::*;
();
	port_op_e op;       // OP_NONE between ops
	gs_chan_t volnum;
	gs_chan_t chan_sel; // a[10:8] of sample read
	gs_data_t data;

	modport src (output op, output volnum, output chan_sel, output data);
	modport dst (input op, input volnum, input chan_sel, input data);
endinterface

// File: hw/gs_ports_pkg.sv
// gs port block types
// decoded operations, config layout and bus-side words

`include "gs_ports_params.svh"

package gs_ports_pkg;

	typedef logic [`GS_DATA_W-1:0]     gs_data_t;
	typedef logic [`GS_CAP_ADDR_W-1:0] gs_cap_addr_t; // a[10:0] of a cycle
	typedef logic [5:0]                gs_port_t;
	typedef logic [2:0]                gs_chan_t;     // channel or volume index

	typedef enum logic [3:0] {
		OP_NONE,
		OP_PAGE0,
		OP_PAGEX,
		OP_DATRD,
		OP_DATWR,
		OP_CLRCBIT,
		OP_MIRROR1,
		OP_MIRROR2,
		OP_CFG,
		OP_VOL,
		OP_SAMPLE
	} port_op_e;

	// same order as port $0f, msb first
	typedef struct packed {
		logic inv7b;
		logic pan4ch;
		logic clksel1;
		logic clksel0;
		logic expag;
		logic chans8;
		logic ramro;
		logic norom;
	} gs_cfg_t;

endpackage

// File: hw/gs_ports_params.svh
// gs port block constants
// port numbers, memory window and config reset value

`ifndef GS_PORTS_PARAMS_SVH
`define GS_PORTS_PARAMS_SVH

`define GS_DATA_W        8       // z80 data bus
`define GS_CAP_ADDR_W    11      // captured a[10:0]

// only ports $00-$3f live here
`define GS_PORT_HI_BITS  2'b00   // a[7:6]
`define GS_MEM_HI_BITS   3'b011  // a[15:13], sample window $6000-$7fff

`define GS_PORT_MPAG     6'h00
`define GS_PORT_ZXCMD    6'h01
`define GS_PORT_ZXDATRD  6'h02
`define GS_PORT_ZXDATWR  6'h03
`define GS_PORT_ZXSTAT   6'h04
`define GS_PORT_CLRCBIT  6'h05
`define GS_PORT_VOL1     6'h06
`define GS_PORT_VOL2     6'h07
`define GS_PORT_VOL3     6'h08
`define GS_PORT_VOL4     6'h09   // bit 5 traced for mirror2
`define GS_PORT_MIRROR1  6'h0a
`define GS_PORT_MIRROR2  6'h0b
`define GS_PORT_GSCFG0   6'h0f
`define GS_PORT_MPAGEX   6'h10
`define GS_PORT_VOL5     6'h16
`define GS_PORT_VOL6     6'h17
`define GS_PORT_VOL7     6'h18
`define GS_PORT_VOL8     6'h19

`define GS_CFG_RESET     8'h30   // both clock selects on

`endif
